// File: posit_pkg.sv
// ========================================
// operation encoding and width functions
// ========================================
package posit_pkg;

    typedef enum logic [1:0] {
        ADD = 2'd0,
        SUB = 2'd1,
        MUL = 2'd2,
        DIV = 2'd3
    } op_t;

    // signed total exponent, room for the doubled range of mul/div
    function automatic int te_size(int n, int es);
        return $clog2(n << es) + 3;
    endfunction

    // hidden bit plus the widest fraction field
    function automatic int mant_size(int n, int es);
        return n - es - 2;
    endfunction

    function automatic int frac_full_size(int n, int es);
        return 2 * mant_size(n, es) + 2;
    endfunction

    // carry bit on top of a mantissa extended by its own width
    function automatic int mant_add_result_size(int n, int es);
        return 2 * mant_size(n, es) + 1;
    endfunction

    // two integer bits, fraction, guard and one spare bit
    function automatic int mant_mul_result_size(int n, int es);
        return mant_size(n, es) + 3;
    endfunction

    function automatic int mant_div_result_size(int n, int es);
        return frac_full_size(n, es);
    endfunction

endpackage

// File: posit_decode.sv
// ========================================
// posit field decoder
// ========================================
module posit_decode #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic [N-1:0]                                posit,
    output logic                                        sign,
    output logic signed [posit_pkg::te_size(N, ES)-1:0] te,
    output logic [posit_pkg::mant_size(N, ES)-1:0]      mant,
    output logic                                        is_zero,
    output logic                                        is_nar
);

    localparam int TE_W = posit_pkg::te_size(N, ES);
    localparam int M    = posit_pkg::mant_size(N, ES);
    localparam int RW   = $clog2(N) + 1;

    logic [N-1:0]           abs_p;
    logic [N-2:0]           body;
    logic [N-2:0]           rest;
    logic [N-2:0]           rest_frac;
    logic                   r0;
    logic                   done;
    logic [RW-1:0]          run;
    logic signed [TE_W-1:0] k;
    logic [TE_W-1:0]        exp_bits;

    assign sign    = posit[N-1];
    assign is_zero = posit == '0;
    assign is_nar  = posit == {1'b1, {(N-1){1'b0}}};

    always_comb begin
        abs_p = sign ? -posit : posit;
        body  = abs_p[N-2:0];
        r0    = body[N-2];

        // length of the regime run, first differing bit ends it
        run  = RW'(1);
        done = 1'b0;
        for (int i = N - 3; i >= 0; i--) begin
            if (done || body[i] != r0) begin
                done = 1'b1;
            end else begin
                run = run + 1'b1;
            end
        end

        k = r0 ? TE_W'(run) - 1 : -TE_W'(run);

        // skip regime and its terminating bit
        rest      = body << (run + 1);
        exp_bits  = TE_W'(rest >> (N - 1 - ES));
        rest_frac = rest << ES;

        te   = (k <<< ES) + exp_bits;
        mant = {1'b1, rest_frac[N-2 -: M-1]};
    end

endmodule

// File: core_add_sub.sv
// ========================================
// mantissa alignment and add/subtract
// ========================================
module core_add_sub #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]         te1_in,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]         te2_in,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]              mant1_in,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]              mant2_in,
    input  logic                                                have_opposite_sign,
    output logic [posit_pkg::mant_add_result_size(N, ES)-1:0]   mant_out,
    output logic signed [posit_pkg::te_size(N, ES)-1:0]         te_out,
    output logic                                                frac_lsb_cut_off
);

    localparam int TE_W = posit_pkg::te_size(N, ES);
    localparam int M    = posit_pkg::mant_size(N, ES);

    logic                   swap;
    logic signed [TE_W-1:0] te_small;
    logic [M-1:0]           mant_big;
    logic [M-1:0]           mant_small;
    logic [TE_W-1:0]        diff;
    logic [TE_W-1:0]        shamt;
    logic [4*M-1:0]         ext;
    logic [2*M-1:0]         big_al;
    logic [2*M-1:0]         small_al;

    always_comb begin
        // larger magnitude goes first
        swap = (te2_in > te1_in) || (te2_in == te1_in && mant2_in > mant1_in);

        te_out     = swap ? te2_in : te1_in;
        te_small   = swap ? te1_in : te2_in;
        mant_big   = swap ? mant2_in : mant1_in;
        mant_small = swap ? mant1_in : mant2_in;

        diff  = te_out - te_small;
        shamt = (diff > TE_W'(2 * M)) ? TE_W'(2 * M) : diff;

        // lower half of ext collects what falls off the aligned operand
        ext              = {mant_small, {(3*M){1'b0}}} >> shamt;
        small_al         = ext[4*M-1:2*M];
        frac_lsb_cut_off = |ext[2*M-1:0];
        big_al           = {mant_big, {M{1'b0}}};

        // lost bits make the true difference slightly smaller
        if (have_opposite_sign) begin
            mant_out = {1'b0, big_al} - {1'b0, small_al} - frac_lsb_cut_off;
        end else begin
            mant_out = {1'b0, big_al} + {1'b0, small_al};
        end
    end

endmodule

// File: core_mul.sv
// ========================================
// mantissa multiplier
// ========================================
module core_mul #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]        te1,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]        te2,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]             mant1,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]             mant2,
    output logic [posit_pkg::mant_mul_result_size(N, ES)-1:0]  mant_out,
    output logic signed [posit_pkg::te_size(N, ES)-1:0]        te_out,
    output logic                                               frac_lsb_cut_off
);

    localparam int M     = posit_pkg::mant_size(N, ES);
    localparam int MUL_W = posit_pkg::mant_mul_result_size(N, ES);

    logic [2*M-1:0] prod;

    // product lies in [1, 4), two integer bits on top
    assign prod = mant1 * mant2;

    assign mant_out         = prod[2*M-1 -: MUL_W];
    assign frac_lsb_cut_off = |prod[2*M-MUL_W-1:0];
    assign te_out           = te1 + te2;

endmodule

// File: core_div.sv
// ========================================
// restoring mantissa divider
// ========================================
module core_div #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]        te1,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]        te2,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]             mant1,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]             mant2,
    output logic [posit_pkg::mant_div_result_size(N, ES)-1:0]  mant_out,
    output logic signed [posit_pkg::te_size(N, ES)-1:0]        te_out
);

    localparam int M   = posit_pkg::mant_size(N, ES);
    localparam int F   = posit_pkg::frac_full_size(N, ES);
    localparam int Q_W = F - 2;

    logic [M:0]     rem;
    logic [Q_W-1:0] q;

    // first step yields the ones bit, the rest are fraction bits
    always_comb begin
        rem = {1'b0, mant1};
        q   = '0;
        for (int i = Q_W - 1; i >= 0; i--) begin
            if (rem >= {1'b0, mant2}) begin
                rem  = rem - {1'b0, mant2};
                q[i] = 1'b1;
            end
            rem = rem << 1;
        end
    end

    // ones bit lands at F-2 like the other cores, sticky at the bottom
    assign mant_out = {1'b0, q, |rem};
    assign te_out   = te1 - te2;

endmodule

// File: core_op.sv
// ========================================
// arithmetic core select
// ========================================
module core_op #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  posit_pkg::op_t                               op,
    input  logic                                         sign1,
    input  logic                                         sign2,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]  te1,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]  te2,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]       mant1,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]       mant2,
    output logic signed [posit_pkg::te_size(N, ES)-1:0]  te_out_core_op,
    output logic [posit_pkg::frac_full_size(N, ES)-1:0]  frac_out_core_op,
    output logic                                         frac_lsb_cut_off
);

    localparam int TE_W  = posit_pkg::te_size(N, ES);
    localparam int F     = posit_pkg::frac_full_size(N, ES);
    localparam int ADD_W = posit_pkg::mant_add_result_size(N, ES);
    localparam int MUL_W = posit_pkg::mant_mul_result_size(N, ES);
    localparam int DIV_W = posit_pkg::mant_div_result_size(N, ES);

    logic [ADD_W-1:0]       mant_add;
    logic [MUL_W-1:0]       mant_mul;
    logic [DIV_W-1:0]       mant_div;
    logic signed [TE_W-1:0] te_add;
    logic signed [TE_W-1:0] te_mul;
    logic signed [TE_W-1:0] te_div;
    logic                   cut_add;
    logic                   cut_mul;
    logic                   opposite;

    // subtract flips the sign of the second operand
    assign opposite = sign1 ^ sign2 ^ (op == posit_pkg::SUB);

    core_add_sub #(.N(N), .ES(ES)) i_add_sub (
        .te1_in             (te1),
        .te2_in             (te2),
        .mant1_in           (mant1),
        .mant2_in           (mant2),
        .have_opposite_sign (opposite),
        .mant_out           (mant_add),
        .te_out             (te_add),
        .frac_lsb_cut_off   (cut_add)
    );

    core_mul #(.N(N), .ES(ES)) i_mul (
        .te1              (te1),
        .te2              (te2),
        .mant1            (mant1),
        .mant2            (mant2),
        .mant_out         (mant_mul),
        .te_out           (te_mul),
        .frac_lsb_cut_off (cut_mul)
    );

    core_div #(.N(N), .ES(ES)) i_div (
        .te1      (te1),
        .te2      (te2),
        .mant1    (mant1),
        .mant2    (mant2),
        .mant_out (mant_div),
        .te_out   (te_div)
    );

    // left-align so bits F-1 and F-2 hold the integer part for every op
    always_comb begin
        case (op)
            posit_pkg::MUL: begin
                frac_out_core_op = F'(mant_mul) << (F - MUL_W);
                te_out_core_op   = te_mul;
                frac_lsb_cut_off = cut_mul;
            end
            posit_pkg::DIV: begin
                // quotient sticky sits in its own lsb
                frac_out_core_op = mant_div;
                te_out_core_op   = te_div;
                frac_lsb_cut_off = 1'b0;
            end
            default: begin
                frac_out_core_op = F'(mant_add) << (F - ADD_W);
                te_out_core_op   = te_add;
                frac_lsb_cut_off = cut_add;
            end
        endcase
    end

endmodule

// File: posit_round_encode.sv
// ========================================
// normalize, round to nearest even, pack
// ========================================
module posit_round_encode #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic                                         sign,
    input  logic signed [posit_pkg::te_size(N, ES)-1:0]  te,
    input  logic [posit_pkg::frac_full_size(N, ES)-1:0]  frac,
    input  logic                                         frac_lsb_cut_off,
    output logic [N-1:0]                                 posit
);

    localparam int TE_W = posit_pkg::te_size(N, ES);
    localparam int F    = posit_pkg::frac_full_size(N, ES);
    localparam int T    = ES + F - 1;
    localparam int W    = T + N + 2;
    localparam logic signed [TE_W-1:0] TE_MAX = TE_W'((N - 2) << ES);
    localparam logic signed [TE_W-1:0] TE_MIN = -TE_MAX;

    int                     lead;
    logic signed [TE_W-1:0] te_n;
    logic signed [TE_W-1:0] te_c;
    logic signed [TE_W-1:0] k;
    logic [TE_W-1:0]        e;
    logic [F-1:0]           norm;
    logic [F-2:0]           frac_bits;
    logic [T-1:0]           tail;
    logic [W-1:0]           v;
    logic [W-1:0]           x;
    logic [N-2:0]           body;
    logic [N-2:0]           body_r;
    logic                   guard;
    logic                   sticky;

    always_comb begin
        // leading one, ones place of frac is bit F-2
        lead = 0;
        for (int i = 0; i < F; i++) begin
            if (frac[i]) begin
                lead = i;
            end
        end
        te_n      = te + TE_W'(lead) - TE_W'(F - 2);
        norm      = frac << (F - 1 - lead);
        frac_bits = norm[F-2:0];

        // saturate to maxpos / minpos
        te_c = te_n;
        if (te_n > TE_MAX) begin
            te_c      = TE_MAX;
            frac_bits = '0;
        end else if (te_n < TE_MIN) begin
            te_c      = TE_MIN;
            frac_bits = '0;
        end

        k    = te_c >>> ES;
        e    = te_c - (k <<< ES);
        tail = (T'(e) << (F - 1)) | T'(frac_bits);

        // regime by shifting: ones fill for k >= 0, zeros for k < 0
        if (k >= 0) begin
            v = {2'b10, tail, {N{1'b0}}};
            x = $signed(v) >>> k;
        end else begin
            v = {2'b01, tail, {N{1'b0}}};
            x = v >> (-k - 1);
        end

        body   = x[W-1 -: N-1];
        guard  = x[W-N];
        sticky = (|x[W-N-1:0]) | frac_lsb_cut_off;

        // all ones only at maxpos, where the guard is the regime stop bit
        body_r = body + (guard & (body[0] | sticky));

        if (frac == '0) begin
            posit = '0;
        end else if (sign) begin
            posit = -{1'b0, body_r};
        end else begin
            posit = {1'b0, body_r};
        end
    end

endmodule

// File: posit_alu.sv
// ========================================
// two-stage posit arithmetic unit
// ========================================
module posit_alu #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    output logic           in_ready,
    input  posit_pkg::op_t in_op,
    input  logic [N-1:0]   in_a,
    input  logic [N-1:0]   in_b,
    output logic           out_valid,
    input  logic           out_ready,
    output logic [N-1:0]   out_result
);

    localparam int TE_W = posit_pkg::te_size(N, ES);
    localparam int M    = posit_pkg::mant_size(N, ES);
    localparam int F    = posit_pkg::frac_full_size(N, ES);
    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

    logic                   sign_a;
    logic                   sign_b;
    logic signed [TE_W-1:0] te_a;
    logic signed [TE_W-1:0] te_b;
    logic [M-1:0]           mant_a;
    logic [M-1:0]           mant_b;
    logic                   zero_a;
    logic                   zero_b;
    logic                   nar_a;
    logic                   nar_b;
    logic                   special;
    logic [N-1:0]           special_res;
    logic                   res_sign;

    // stage 1 registers
    logic                   s1_valid;
    posit_pkg::op_t         s1_op;
    logic                   s1_sign_a;
    logic                   s1_sign_b;
    logic signed [TE_W-1:0] s1_te_a;
    logic signed [TE_W-1:0] s1_te_b;
    logic [M-1:0]           s1_mant_a;
    logic [M-1:0]           s1_mant_b;
    logic                   s1_res_sign;
    logic                   s1_special;
    logic [N-1:0]           s1_special_res;

    logic signed [TE_W-1:0] core_te;
    logic [F-1:0]           core_frac;
    logic                   core_cut;
    logic [N-1:0]           rounded;
    logic [N-1:0]           s2_result;
    logic                   s2_ready;
    logic                   s1_adv;

    posit_decode #(.N(N), .ES(ES)) i_dec_a (
        .posit (in_a),
        .sign  (sign_a),
        .te    (te_a),
        .mant  (mant_a),
        .is_zero (zero_a),
        .is_nar  (nar_a)
    );

    posit_decode #(.N(N), .ES(ES)) i_dec_b (
        .posit (in_b),
        .sign  (sign_b),
        .te    (te_b),
        .mant  (mant_b),
        .is_zero (zero_b),
        .is_nar  (nar_b)
    );

    // zero and NaR bypass the arithmetic path
    always_comb begin
        special     = zero_a || zero_b;
        special_res = '0;
        if (nar_a || nar_b) begin
            special     = 1'b1;
            special_res = NAR;
        end else if (in_op == posit_pkg::DIV) begin
            special_res = zero_b ? NAR : '0;
        end else if (in_op == posit_pkg::ADD || in_op == posit_pkg::SUB) begin
            if (zero_b) begin
                special_res = in_a;
            end else begin
                special_res = (in_op == posit_pkg::SUB) ? -in_b : in_b;
            end
        end
    end

    // add/sub sign follows the larger magnitude, same tie rule as the core
    always_comb begin
        if (in_op == posit_pkg::MUL || in_op == posit_pkg::DIV) begin
            res_sign = sign_a ^ sign_b;
        end else if ((te_a > te_b) || (te_a == te_b && mant_a >= mant_b)) begin
            res_sign = sign_a;
        end else begin
            res_sign = sign_b ^ (in_op == posit_pkg::SUB);
        end
    end

    // pipeline handshake
    assign s2_ready  = !out_valid || out_ready;
    assign s1_adv    = s1_valid && s2_ready;
    assign in_ready  = !s1_valid || s2_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_ready) begin
                out_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_op          <= in_op;
            s1_sign_a      <= sign_a;
            s1_sign_b      <= sign_b;
            s1_te_a        <= te_a;
            s1_te_b        <= te_b;
            s1_mant_a      <= mant_a;
            s1_mant_b      <= mant_b;
            s1_res_sign    <= res_sign;
            s1_special     <= special;
            s1_special_res <= special_res;
        end
        if (s1_adv) begin
            s2_result <= s1_special ? s1_special_res : rounded;
        end
    end

    core_op #(.N(N), .ES(ES)) i_core_op (
        .op               (s1_op),
        .sign1            (s1_sign_a),
        .sign2            (s1_sign_b),
        .te1              (s1_te_a),
        .te2              (s1_te_b),
        .mant1            (s1_mant_a),
        .mant2            (s1_mant_b),
        .te_out_core_op   (core_te),
        .frac_out_core_op (core_frac),
        .frac_lsb_cut_off (core_cut)
    );

    posit_round_encode #(.N(N), .ES(ES)) i_round (
        .sign             (s1_res_sign),
        .te               (core_te),
        .frac             (core_frac),
        .frac_lsb_cut_off (core_cut),
        .posit            (rounded)
    );

    assign out_result = s2_result;

endmodule

// File: posit_alu_tb.sv
// ========================================
// testbench for the two-stage posit ALU
// ========================================
module posit_alu_tb;

    localparam int N       = 16;
    localparam int ES      = 1;
    localparam int TIMEOUT = 200;

    logic           clk;
    logic           arst_n;
    logic           in_valid;
    logic           in_ready;
    posit_pkg::op_t in_op;
    logic [N-1:0]   in_a;
    logic [N-1:0]   in_b;
    logic           out_valid;
    logic           out_ready;
    logic [N-1:0]   out_result;

    // stimulus table, posit16 es=1 patterns
    posit_pkg::op_t tbl_op[$];
    logic [N-1:0]   tbl_a[$];
    logic [N-1:0]   tbl_b[$];
    logic [N-1:0]   tbl_exp[$];
    int             accept_cycle[$];

    int             cycle;
    logic           hold_ready;
    logic [31:0]    lcg_state;

    posit_alu #(.N(N), .ES(ES)) i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial cycle = 0;
    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // random back-pressure until the latency pass
    always @(posedge clk) begin
        if (hold_ready) begin
            out_ready <= 1'b1;
        end else begin
            lcg_state = next_random(lcg_state);
            out_ready <= lcg_state[20];
        end
    end

    task automatic add_entry(input posit_pkg::op_t op, input logic [N-1:0] a,
                             input logic [N-1:0] b, input logic [N-1:0] exp);
        tbl_op.push_back(op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_exp.push_back(exp);
    endtask

    task automatic load_table();
        // exact results
        add_entry(posit_pkg::ADD, 16'h4000, 16'h4000, 16'h5000);
        add_entry(posit_pkg::SUB, 16'h5800, 16'h4000, 16'h5000);
        add_entry(posit_pkg::MUL, 16'h4800, 16'h5000, 16'h5800);
        add_entry(posit_pkg::DIV, 16'h6400, 16'h5000, 16'h5800);
        add_entry(posit_pkg::ADD, 16'hB000, 16'h3000, 16'hB800);
        add_entry(posit_pkg::SUB, 16'h4000, 16'hC000, 16'h5000);
        add_entry(posit_pkg::SUB, 16'h3000, 16'h5000, 16'hB800);
        // 1.0 + 2^-13 is a tie, even neighbour is 1.0
        add_entry(posit_pkg::ADD, 16'h4000, 16'h00C0, 16'h4000);
        // 1/3 rounds down, 16/3 has guard and remainder set
        add_entry(posit_pkg::DIV, 16'h4000, 16'h5800, 16'h2555);
        add_entry(posit_pkg::DIV, 16'h7000, 16'h5800, 16'h62AB);
        // 0.75 ulp above 2.25, rounds up
        add_entry(posit_pkg::MUL, 16'h4801, 16'h4800, 16'h5201);
        // saturation at maxpos and minpos
        add_entry(posit_pkg::MUL, 16'h7FFF, 16'h7FFF, 16'h7FFF);
        add_entry(posit_pkg::MUL, 16'h0001, 16'h0001, 16'h0001);
        // zero and NaR
        add_entry(posit_pkg::DIV, 16'h5000, 16'h0000, 16'h8000);
        add_entry(posit_pkg::ADD, 16'h8000, 16'h4000, 16'h8000);
        add_entry(posit_pkg::MUL, 16'h5800, 16'h8000, 16'h8000);
        add_entry(posit_pkg::DIV, 16'h0000, 16'h0000, 16'h8000);
        add_entry(posit_pkg::MUL, 16'h0000, 16'h5800, 16'h0000);
        add_entry(posit_pkg::DIV, 16'h0000, 16'h5000, 16'h0000);
        add_entry(posit_pkg::ADD, 16'h5800, 16'h0000, 16'h5800);
        add_entry(posit_pkg::SUB, 16'h0000, 16'h5800, 16'hA800);
        add_entry(posit_pkg::SUB, 16'h5800, 16'h5800, 16'h0000);
    endtask

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input logic [N-1:0] got, input logic [N-1:0] exp,
                                input int idx);
        if (got !== exp) begin
            $display("Mismatch at time %0t: out_result (entry %0d) got %h expected %h",
                     $time, idx, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input int got, input int exp, input int idx);
        if (got != exp) begin
            $display("Mismatch at time %0t: latency (entry %0d) got %0d expected %0d",
                     $time, idx, got, exp);
            stop_on_error();
        end
    endtask

    task automatic drive_table(input logic keep_ready);
        int waited;
        for (int i = 0; i < tbl_op.size(); i++) begin
            in_valid <= 1'b1;
            in_op    <= tbl_op[i];
            in_a     <= tbl_a[i];
            in_b     <= tbl_b[i];
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timeout at time %0t: entry %0d was never accepted", $time, i);
                    stop_on_error();
                end
            end while (!in_ready);
            accept_cycle.push_back(cycle);
            if (keep_ready && waited != 1) begin
                $display("in_ready dropped at time %0t although out_ready stayed high",
                         $time);
                stop_on_error();
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic watch_output(input logic check_lat);
        int waited;
        for (int i = 0; i < tbl_exp.size(); i++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timeout at time %0t: no result for entry %0d", $time, i);
                    stop_on_error();
                end
            end while (!(out_valid && out_ready));
            check_result(out_result, tbl_exp[i], i);
            if (check_lat) begin
                check_latency(cycle - accept_cycle[i], 2, i);
            end
        end
    endtask

    task automatic run_pass(input logic check_lat);
        accept_cycle.delete();
        fork
            drive_table(check_lat);
            watch_output(check_lat);
        join
    endtask

    initial begin
        lcg_state  = 32'h0434_67ab;
        hold_ready = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_op      = posit_pkg::ADD;
        in_a       = '0;
        in_b       = '0;
        out_ready  = 1'b0;
        load_table();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        // first pass under random back-pressure
        run_pass(1'b0);
        @(negedge clk);
        hold_ready = 1'b1;
        @(posedge clk);
        // second pass with the output always ready
        run_pass(1'b1);
        $display("No errors");
        $finish;
    end

endmodule

// File: posit_alu.f
posit_pkg.sv
posit_decode.sv
core_add_sub.sv
core_mul.sv
core_div.sv
core_op.sv
posit_round_encode.sv
posit_alu.sv
posit_alu_tb.sv
